// File: sim.f
verilog/axi_mem_pkg.sv
verilog/sram_bank.sv
verilog/mem_port_arbiter.sv
verilog/axi_wr_engine.sv
verilog/axi_rd_engine.sv
verilog/axi_mem_slave.sv
verification/axi_mem_slave_assert.sv
verification/axi_mem_slave_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module axi_mem_slave_tb -o axi_mem_slave_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/axi_mem_slave_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation passed"
exit 0

// File: verification/axi_mem_slave_tb.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_slave_tb;

  import axi_mem_pkg::*;

  localparam int DATA_WIDTH  = 32;
  localparam int MEM_WORDS   = 256;
  localparam int BYTES       = DATA_WIDTH / 8;
  localparam logic [SIZE_BITS-1:0] SIZE_FULL = SIZE_BITS'($clog2(BYTES));
  localparam int TOTAL_BEATS = 131;  // upper bound over all tests.

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic [ID_BITS-1:0]    awid_i;
  logic [31:0]           awaddr_i;
  logic [LEN_BITS-1:0]   awlen_i;
  logic [SIZE_BITS-1:0]  awsize_i;
  logic [BURST_BITS-1:0] awburst_i;
  logic                  awvalid_i;
  logic                  awready_o;
  logic [DATA_WIDTH-1:0] wdata_i;
  logic [BYTES-1:0]      wstrb_i;
  logic                  wlast_i;
  logic                  wvalid_i;
  logic                  wready_o;
  logic [ID_BITS-1:0]    bid_o;
  logic [RESP_BITS-1:0]  bresp_o;
  logic                  bvalid_o;
  logic                  bready_i;
  logic [ID_BITS-1:0]    arid_i;
  logic [31:0]           araddr_i;
  logic [LEN_BITS-1:0]   arlen_i;
  logic [SIZE_BITS-1:0]  arsize_i;
  logic [BURST_BITS-1:0] arburst_i;
  logic                  arvalid_i;
  logic                  arready_o;
  logic [ID_BITS-1:0]    rid_o;
  logic [DATA_WIDTH-1:0] rdata_o;
  logic [RESP_BITS-1:0]  rresp_o;
  logic                  rlast_o;
  logic                  rvalid_o;
  logic                  rready_i;

  logic [7:0]            model_mem [MEM_WORDS*BYTES];  // byte-level image of the bank.
  logic [DATA_WIDTH-1:0] wbeat_data [256];
  logic [BYTES-1:0]      wbeat_strb [256];
  logic [31:0]           lcg_state = 32'hed53_2f86;
  int                    data_errs = 0;
  int                    resp_errs = 0;
  int                    id_errs = 0;
  int                    last_errs = 0;
  int                    proto_errs = 0;

  axi_mem_slave dut_i (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int beat_word(input logic [31:0] addr, input logic [BURST_BITS-1:0] burst,
                                   input int beat);
    return int'(addr / BYTES) + ((burst == BURST_FIXED) ? 0 : beat);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] model_word(input int word);
    logic [DATA_WIDTH-1:0] w;
    for (int b = 0; b < BYTES; b++) begin
      w[b*8 +: 8] = model_mem[word*BYTES + b];
    end
    return w;
  endfunction

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp_val,
                            input logic [DATA_WIDTH-1:0] act_val);
    if (act_val !== exp_val) begin
      data_errs++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_resp(input string name, input logic [RESP_BITS-1:0] exp_val,
                            input logic [RESP_BITS-1:0] act_val);
    if (act_val !== exp_val) begin
      resp_errs++;
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_id(input string name, input logic [ID_BITS-1:0] exp_val,
                          input logic [ID_BITS-1:0] act_val);
    if (act_val !== exp_val) begin
      id_errs++;
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_last(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      last_errs++;
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp_val, act_val);
    end
  endtask

  task automatic axi_write_burst(input logic [ID_BITS-1:0] id, input logic [31:0] addr,
                                 input logic [LEN_BITS-1:0] len,
                                 input logic [SIZE_BITS-1:0] size,
                                 input logic [BURST_BITS-1:0] burst, input int b_delay);
    logic bad;
    logic err;
    int   word;
    bad = (burst == BURST_WRAP) || (size != SIZE_FULL);
    err = bad;
    @(posedge clk_i);
    awid_i    <= id;
    awaddr_i  <= addr;
    awlen_i   <= len;
    awsize_i  <= size;
    awburst_i <= burst;
    awvalid_i <= 1'b1;
    do @(negedge clk_i); while (!awready_o);
    for (int beat = 0; beat <= int'(len); beat++) begin
      @(posedge clk_i);
      awvalid_i <= 1'b0;
      wdata_i   <= wbeat_data[beat];
      wstrb_i   <= wbeat_strb[beat];
      wlast_i   <= (beat == int'(len));
      wvalid_i  <= 1'b1;
      do @(negedge clk_i); while (!wready_o);
      word = beat_word(addr, burst, beat);
      if (bad || word >= MEM_WORDS) begin
        err = 1'b1;  // the slave drops this beat.
      end else begin
        for (int b = 0; b < BYTES; b++) begin
          if (wbeat_strb[beat][b]) begin
            model_mem[word*BYTES + b] = wbeat_data[beat][b*8 +: 8];
          end
        end
      end
    end
    @(posedge clk_i);
    wvalid_i <= 1'b0;
    wlast_i  <= 1'b0;
    repeat (b_delay) @(posedge clk_i);
    bready_i <= 1'b1;
    do @(negedge clk_i); while (!bvalid_o);
    check_id("bid", id, bid_o);
    check_resp("bresp", err ? RESP_SLVERR : RESP_OKAY, bresp_o);
    @(posedge clk_i);
    bready_i <= 1'b0;
  endtask

  task automatic axi_read_burst(input logic [ID_BITS-1:0] id, input logic [31:0] addr,
                                input logic [LEN_BITS-1:0] len,
                                input logic [SIZE_BITS-1:0] size,
                                input logic [BURST_BITS-1:0] burst, input bit stall);
    logic bad;
    logic beat_err;
    int   word;
    bad = (burst == BURST_WRAP) || (size != SIZE_FULL);
    @(posedge clk_i);
    arid_i    <= id;
    araddr_i  <= addr;
    arlen_i   <= len;
    arsize_i  <= size;
    arburst_i <= burst;
    arvalid_i <= 1'b1;
    do @(negedge clk_i); while (!arready_o);
    @(posedge clk_i);
    arvalid_i <= 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      if (stall) begin
        rready_i <= 1'b0;
        repeat (next_random() % 4) @(posedge clk_i);
      end
      rready_i <= 1'b1;
      do @(negedge clk_i); while (!rvalid_o);
      word = beat_word(addr, burst, beat);
      beat_err = bad || (word >= MEM_WORDS);  // erred beats come back as zero.
      check_data("rdata", beat_err ? '0 : model_word(word), rdata_o);
      check_resp("rresp", beat_err ? RESP_SLVERR : RESP_OKAY, rresp_o);
      check_id("rid", id, rid_o);
      check_last("rlast", beat == int'(len), rlast_o);
      @(posedge clk_i);
    end
    rready_i <= 1'b0;
    @(negedge clk_i);
    if (rvalid_o) begin
      proto_errs++;
      $display("a read burst at %0t ns returned more beats than it asked for", $time);
    end
  endtask

  task automatic fill_beats(input int count, input bit random_strb);
    for (int i = 0; i < count; i++) begin
      wbeat_data[i] = next_random();
      wbeat_strb[i] = random_strb ? BYTES'(next_random()) : '1;
    end
  endtask

  task automatic single_beat_rw();
    int words [4] = '{0, 7, 130, 255};
    for (int i = 0; i < 4; i++) begin
      fill_beats(1, 1'b0);
      axi_write_burst(ID_BITS'(i + 1), 32'(words[i] * BYTES), 0, SIZE_FULL, BURST_INCR, 0);
      axi_read_burst(ID_BITS'(i + 9), 32'(words[i] * BYTES), 0, SIZE_FULL, BURST_INCR, 1'b0);
    end
  endtask

  task automatic incr_burst_rw();
    logic [LEN_BITS-1:0] len;
    len = LEN_BITS'(next_random() % 16 + 1);
    fill_beats(int'(len) + 1, 1'b1);
    axi_write_burst(4'd3, 32'(16 * BYTES), len, SIZE_FULL, BURST_INCR, 0);
    axi_read_burst(4'd4, 32'(16 * BYTES), len, SIZE_FULL, BURST_INCR, 1'b0);
  endtask

  task automatic fixed_burst_rw();
    fill_beats(4, 1'b1);
    axi_write_burst(4'd5, 32'(64 * BYTES), 3, SIZE_FULL, BURST_FIXED, 0);
    axi_read_burst(4'd6, 32'(64 * BYTES), 3, SIZE_FULL, BURST_FIXED, 1'b0);
  endtask

  task automatic concurrent_rw();
    fill_beats(8, 1'b0);
    fork
      axi_write_burst(4'd7, 32'(96 * BYTES), 7, SIZE_FULL, BURST_INCR, 0);
      axi_read_burst(4'd8, 32'(16 * BYTES), 7, SIZE_FULL, BURST_INCR, 1'b0);
    join
  endtask

  task automatic error_responses();
    fill_beats(4, 1'b0);
    axi_write_burst(4'd9, 32'(200 * BYTES), 1, SIZE_FULL, BURST_WRAP, 0);
    axi_write_burst(4'd10, 32'(202 * BYTES), 0, 3'd1, BURST_INCR, 0);
    axi_write_burst(4'd11, 32'(254 * BYTES), 3, SIZE_FULL, BURST_INCR, 0);  // runs off the end.
    axi_read_burst(4'd12, 32'(200 * BYTES), 1, SIZE_FULL, BURST_WRAP, 1'b0);
    axi_read_burst(4'd13, 32'(202 * BYTES), 0, 3'd1, BURST_INCR, 1'b0);
    axi_read_burst(4'd14, 32'(254 * BYTES), 3, SIZE_FULL, BURST_INCR, 1'b0);
    axi_read_burst(4'd15, 32'(200 * BYTES), 2, SIZE_FULL, BURST_INCR, 1'b0);
  endtask

  task automatic backpressure_rw();
    for (int k = 0; k < 2; k++) begin
      fill_beats(12, 1'b1);
      axi_write_burst(ID_BITS'(k), 32'((32 + 12 * k) * BYTES), 11, SIZE_FULL, BURST_INCR,
                      int'(next_random() % 8));
      axi_read_burst(ID_BITS'(k + 2), 32'((32 + 12 * k) * BYTES), 11, SIZE_FULL, BURST_INCR,
                     1'b1);
    end
  endtask

  initial begin
    repeat (TOTAL_BEATS * 40 + 2000) @(posedge clk_i);
    $display("timeout: the tests stopped making progress before the end of the run");
    $display("Errors found");
    $finish;
  end

  initial begin
    rst_i     = 1'b1;
    awid_i    = '0;
    awaddr_i  = '0;
    awlen_i   = '0;
    awsize_i  = '0;
    awburst_i = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wlast_i   = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    arid_i    = '0;
    araddr_i  = '0;
    arlen_i   = '0;
    arsize_i  = '0;
    arburst_i = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    for (int i = 0; i < MEM_WORDS * BYTES; i++) begin
      model_mem[i] = 8'h00;  // the bank powers up cleared.
    end
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    single_beat_rw();
    incr_burst_rw();
    fixed_burst_rw();
    concurrent_rw();
    error_responses();
    backpressure_rw();
    $display("error counts: data %0d, response %0d, id %0d, rlast %0d, protocol %0d",
             data_errs, resp_errs, id_errs, last_errs, proto_errs);
    if (data_errs + resp_errs + id_errs + last_errs + proto_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/axi_mem_slave_assert.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_slave_assert #(
  parameter int DATA_WIDTH = 32
) (
  input logic                            clk_i,
  input logic                            rst_i,
  input logic                            bvalid_i,
  input logic                            bready_i,
  input logic                            rvalid_i,
  input logic                            rready_i,
  input logic [DATA_WIDTH-1:0]           rdata_i,
  input logic                            rlast_i,
  input logic [axi_mem_pkg::ID_BITS-1:0] rid_i
);

  bvalid_held: assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid fell before the B transfer");

  rvalid_held: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid fell before the R transfer");

  r_payload_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i && !rready_i |=> $stable(rdata_i) && $stable(rlast_i) && $stable(rid_i))
    else $error("R payload changed while the beat was stalled");

endmodule

bind axi_mem_slave axi_mem_slave_assert #(.DATA_WIDTH(DATA_WIDTH)) assert_i (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .bvalid_i (bvalid_o),
  .bready_i (bready_i),
  .rvalid_i (rvalid_o),
  .rready_i (rready_i),
  .rdata_i  (rdata_o),
  .rlast_i  (rlast_o),
  .rid_i    (rid_o)
);

`default_nettype wire

// File: verilog/axi_mem_slave.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_slave #(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256,
  localparam int ADDR_WIDTH = 32,
  localparam int INDEX_BITS = $clog2(MEM_WORDS)
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [axi_mem_pkg::ID_BITS-1:0]    awid_i,
  input  logic [ADDR_WIDTH-1:0]              awaddr_i,
  input  logic [axi_mem_pkg::LEN_BITS-1:0]   awlen_i,
  input  logic [axi_mem_pkg::SIZE_BITS-1:0]  awsize_i,
  input  logic [axi_mem_pkg::BURST_BITS-1:0] awburst_i,
  input  logic                               awvalid_i,
  output logic                               awready_o,
  input  logic [DATA_WIDTH-1:0]              wdata_i,
  input  logic [DATA_WIDTH/8-1:0]            wstrb_i,
  input  logic                               wlast_i,
  input  logic                               wvalid_i,
  output logic                               wready_o,
  output logic [axi_mem_pkg::ID_BITS-1:0]    bid_o,
  output logic [axi_mem_pkg::RESP_BITS-1:0]  bresp_o,
  output logic                               bvalid_o,
  input  logic                               bready_i,
  input  logic [axi_mem_pkg::ID_BITS-1:0]    arid_i,
  input  logic [ADDR_WIDTH-1:0]              araddr_i,
  input  logic [axi_mem_pkg::LEN_BITS-1:0]   arlen_i,
  input  logic [axi_mem_pkg::SIZE_BITS-1:0]  arsize_i,
  input  logic [axi_mem_pkg::BURST_BITS-1:0] arburst_i,
  input  logic                               arvalid_i,
  output logic                               arready_o,
  output logic [axi_mem_pkg::ID_BITS-1:0]    rid_o,
  output logic [DATA_WIDTH-1:0]              rdata_o,
  output logic [axi_mem_pkg::RESP_BITS-1:0]  rresp_o,
  output logic                               rlast_o,
  output logic                               rvalid_o,
  input  logic                               rready_i
);

  logic                    wr_req;
  logic                    wr_gnt;
  logic [INDEX_BITS-1:0]   wr_index;
  logic [DATA_WIDTH-1:0]   wr_data;
  logic [DATA_WIDTH/8-1:0] wr_strb;
  logic                    rd_req;
  logic                    rd_gnt;
  logic [INDEX_BITS-1:0]   rd_index;
  logic                    mem_cs;
  logic                    mem_we;
  logic [INDEX_BITS-1:0]   mem_index;
  logic [DATA_WIDTH-1:0]   mem_wdata;
  logic [DATA_WIDTH/8-1:0] mem_strb;
  logic [DATA_WIDTH-1:0]   mem_rdata;

  axi_wr_engine #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) wr_engine_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awid_i    (awid_i),
    .awaddr_i  (awaddr_i),
    .awlen_i   (awlen_i),
    .awsize_i  (awsize_i),
    .awburst_i (awburst_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wlast_i   (wlast_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bid_o     (bid_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .req_o     (wr_req),
    .gnt_i     (wr_gnt),
    .index_o   (wr_index),
    .wdata_o   (wr_data),
    .wstrb_o   (wr_strb)
  );

  axi_rd_engine #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) rd_engine_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .arid_i      (arid_i),
    .araddr_i    (araddr_i),
    .arlen_i     (arlen_i),
    .arsize_i    (arsize_i),
    .arburst_i   (arburst_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rid_o       (rid_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rlast_o     (rlast_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .req_o       (rd_req),
    .gnt_i       (rd_gnt),
    .index_o     (rd_index),
    .mem_rdata_i (mem_rdata)
  );

  mem_port_arbiter #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) arbiter_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_req_i   (wr_req),
    .wr_index_i (wr_index),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .rd_req_i   (rd_req),
    .rd_index_i (rd_index),
    .wr_gnt_o   (wr_gnt),
    .rd_gnt_o   (rd_gnt),
    .cs_o       (mem_cs),
    .we_o       (mem_we),
    .index_o    (mem_index),
    .wdata_o    (mem_wdata),
    .strb_o     (mem_strb)
  );

  sram_bank #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) bank_i (
    .clk_i   (clk_i),
    .cs_i    (mem_cs),
    .we_i    (mem_we),
    .index_i (mem_index),
    .wdata_i (mem_wdata),
    .strb_i  (mem_strb),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: verilog/axi_rd_engine.sv
`timescale 1ns/1ns
`default_nettype none

module axi_rd_engine #(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256,
  localparam int ADDR_WIDTH = 32,
  localparam int INDEX_BITS = $clog2(MEM_WORDS)
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [axi_mem_pkg::ID_BITS-1:0]    arid_i,
  input  logic [ADDR_WIDTH-1:0]              araddr_i,
  input  logic [axi_mem_pkg::LEN_BITS-1:0]   arlen_i,
  input  logic [axi_mem_pkg::SIZE_BITS-1:0]  arsize_i,
  input  logic [axi_mem_pkg::BURST_BITS-1:0] arburst_i,
  input  logic                               arvalid_i,
  output logic                               arready_o,
  output logic [axi_mem_pkg::ID_BITS-1:0]    rid_o,
  output logic [DATA_WIDTH-1:0]              rdata_o,
  output logic [axi_mem_pkg::RESP_BITS-1:0]  rresp_o,
  output logic                               rlast_o,
  output logic                               rvalid_o,
  input  logic                               rready_i,
  output logic                               req_o,
  input  logic                               gnt_i,
  output logic [INDEX_BITS-1:0]              index_o,
  input  logic [DATA_WIDTH-1:0]              mem_rdata_i
);

  import axi_mem_pkg::*;

  localparam int OFFSET_BITS = $clog2(DATA_WIDTH / 8);
  localparam int WORD_BITS   = ADDR_WIDTH - OFFSET_BITS;
  localparam logic [SIZE_BITS-1:0] SIZE_FULL = SIZE_BITS'(OFFSET_BITS);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_BUSY = 1'b1;

  logic                  state_q;
  logic                  state_d;
  logic                  arready_q;
  logic [ID_BITS-1:0]    id_q;
  logic [WORD_BITS-1:0]  word_q;
  logic [LEN_BITS:0]     left_q;       // beats not yet issued.
  logic                  fixed_q;
  logic                  bad_burst_q;
  logic                  pend_q;       // a beat lands in the buffer this cycle.
  logic                  pend_err_q;
  logic                  pend_last_q;
  logic [DATA_WIDTH-1:0] buf_data_q [2];
  logic [1:0]            buf_err_q;
  logic [1:0]            buf_last_q;
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic [1:0]            fill_q;
  logic [1:0]            used;
  logic                  ar_fire;
  logic                  r_fire;
  logic                  beat_bad;
  logic                  can_issue;
  logic                  issue;

  assign ar_fire   = arvalid_i & arready_q;
  assign r_fire    = rvalid_o & rready_i;
  assign beat_bad  = bad_burst_q | (word_q >= WORD_BITS'(MEM_WORDS));
  assign used      = fill_q + {1'b0, pend_q};  // in flight counts against buffer space.
  assign can_issue = (state_q == ST_BUSY) & (left_q != '0) & ((used < 2'd2) | r_fire);
  assign req_o     = can_issue & ~beat_bad;
  assign issue     = can_issue & (beat_bad | gnt_i);
  assign index_o   = word_q[INDEX_BITS-1:0];

  assign arready_o = arready_q;
  assign rvalid_o  = (fill_q != 2'd0);
  assign rid_o     = id_q;
  assign rdata_o   = buf_data_q[rd_ptr_q];
  assign rresp_o   = buf_err_q[rd_ptr_q] ? RESP_SLVERR : RESP_OKAY;
  assign rlast_o   = buf_last_q[rd_ptr_q];

  always_comb begin
    state_d = state_q;
    if (state_q == ST_IDLE && ar_fire) begin
      state_d = ST_BUSY;
    end else if (state_q == ST_BUSY && r_fire && rlast_o) begin
      state_d = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      arready_q <= 1'b0;
      left_q    <= '0;
      pend_q    <= 1'b0;
      wr_ptr_q  <= 1'b0;
      rd_ptr_q  <= 1'b0;
      fill_q    <= 2'd0;
    end else begin
      state_q   <= state_d;
      arready_q <= (state_d == ST_IDLE);
      pend_q    <= issue;
      if (ar_fire) begin
        left_q <= {1'b0, arlen_i} + 1'b1;
      end else if (issue) begin
        left_q <= left_q - 1'b1;
      end
      if (pend_q) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (r_fire) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      fill_q <= fill_q + {1'b0, pend_q} - {1'b0, r_fire};
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q        <= arid_i;
      word_q      <= araddr_i[ADDR_WIDTH-1:OFFSET_BITS];
      fixed_q     <= (arburst_i == BURST_FIXED);
      bad_burst_q <= !(arburst_i inside {BURST_FIXED, BURST_INCR}) ||
                     (arsize_i != SIZE_FULL);
    end else if (issue && !fixed_q) begin
      word_q <= word_q + 1'b1;
    end
    if (issue) begin
      pend_err_q  <= beat_bad;
      pend_last_q <= (left_q == {{LEN_BITS{1'b0}}, 1'b1});
    end
    if (pend_q) begin
      buf_data_q[wr_ptr_q] <= pend_err_q ? '0 : mem_rdata_i;  // bank word from last cycle's grant.
      buf_err_q[wr_ptr_q]  <= pend_err_q;
      buf_last_q[wr_ptr_q] <= pend_last_q;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_wr_engine.sv
`timescale 1ns/1ns
`default_nettype none

module axi_wr_engine #(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256,
  localparam int ADDR_WIDTH = 32,
  localparam int INDEX_BITS = $clog2(MEM_WORDS)
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [axi_mem_pkg::ID_BITS-1:0]    awid_i,
  input  logic [ADDR_WIDTH-1:0]              awaddr_i,
  input  logic [axi_mem_pkg::LEN_BITS-1:0]   awlen_i,
  input  logic [axi_mem_pkg::SIZE_BITS-1:0]  awsize_i,
  input  logic [axi_mem_pkg::BURST_BITS-1:0] awburst_i,
  input  logic                               awvalid_i,
  output logic                               awready_o,
  input  logic [DATA_WIDTH-1:0]              wdata_i,
  input  logic [DATA_WIDTH/8-1:0]            wstrb_i,
  input  logic                               wlast_i,
  input  logic                               wvalid_i,
  output logic                               wready_o,
  output logic [axi_mem_pkg::ID_BITS-1:0]    bid_o,
  output logic [axi_mem_pkg::RESP_BITS-1:0]  bresp_o,
  output logic                               bvalid_o,
  input  logic                               bready_i,
  output logic                               req_o,
  input  logic                               gnt_i,
  output logic [INDEX_BITS-1:0]              index_o,
  output logic [DATA_WIDTH-1:0]              wdata_o,
  output logic [DATA_WIDTH/8-1:0]            wstrb_o
);

  import axi_mem_pkg::*;

  localparam int OFFSET_BITS = $clog2(DATA_WIDTH / 8);
  localparam int WORD_BITS   = ADDR_WIDTH - OFFSET_BITS;
  localparam logic [SIZE_BITS-1:0] SIZE_FULL = SIZE_BITS'(OFFSET_BITS);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;
  localparam logic [1:0] ST_RESP = 2'd2;

  logic [1:0]           state_q;
  logic [1:0]           state_d;
  logic                 awready_q;
  logic [ID_BITS-1:0]   id_q;
  logic [WORD_BITS-1:0] word_q;
  logic [LEN_BITS-1:0]  cnt_q;        // beats left after the current one.
  logic                 fixed_q;
  logic                 bad_burst_q;
  logic                 err_q;
  logic                 beat_bad;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 w_last;

  assign beat_bad = bad_burst_q | (word_q >= WORD_BITS'(MEM_WORDS));
  assign aw_fire  = awvalid_i & awready_q;
  assign w_fire   = wvalid_i & wready_o;
  assign w_last   = wlast_i | (cnt_q == '0);  // the count also ends a burst with a missing wlast.

  assign awready_o = awready_q;
  assign wready_o  = (state_q == ST_DATA) & (beat_bad | gnt_i);  // bad beats are swallowed here.
  assign req_o     = (state_q == ST_DATA) & wvalid_i & ~beat_bad;
  assign index_o   = word_q[INDEX_BITS-1:0];
  assign wdata_o   = wdata_i;
  assign wstrb_o   = wstrb_i;
  assign bvalid_o  = (state_q == ST_RESP);
  assign bid_o     = id_q;
  assign bresp_o   = err_q ? RESP_SLVERR : RESP_OKAY;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (aw_fire) begin
          state_d = ST_DATA;
        end
      end
      ST_DATA: begin
        if (w_fire && w_last) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        if (bready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      awready_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      awready_q <= (state_d == ST_IDLE);
      if (aw_fire) begin
        err_q <= 1'b0;
      end else if (w_fire && beat_bad) begin
        err_q <= 1'b1;  // sticky until the next burst.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      id_q        <= awid_i;
      word_q      <= awaddr_i[ADDR_WIDTH-1:OFFSET_BITS];
      cnt_q       <= awlen_i;
      fixed_q     <= (awburst_i == BURST_FIXED);
      bad_burst_q <= !(awburst_i inside {BURST_FIXED, BURST_INCR}) ||
                     (awsize_i != SIZE_FULL);
    end else if (w_fire) begin
      cnt_q <= cnt_q - 1'b1;
      if (!fixed_q) begin
        word_q <= word_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_port_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_port_arbiter #(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256,
  localparam int INDEX_BITS = $clog2(MEM_WORDS)
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    wr_req_i,
  input  logic [INDEX_BITS-1:0]   wr_index_i,
  input  logic [DATA_WIDTH-1:0]   wr_data_i,
  input  logic [DATA_WIDTH/8-1:0] wr_strb_i,
  input  logic                    rd_req_i,
  input  logic [INDEX_BITS-1:0]   rd_index_i,
  output logic                    wr_gnt_o,
  output logic                    rd_gnt_o,
  output logic                    cs_o,
  output logic                    we_o,
  output logic [INDEX_BITS-1:0]   index_o,
  output logic [DATA_WIDTH-1:0]   wdata_o,
  output logic [DATA_WIDTH/8-1:0] strb_o
);

  logic last_wr_q;  // the write engine held the port last.

  // on a tie the engine that waited last time wins.
  assign wr_gnt_o = wr_req_i & (~rd_req_i | ~last_wr_q);
  assign rd_gnt_o = rd_req_i & ~wr_gnt_o;

  assign cs_o    = wr_gnt_o | rd_gnt_o;
  assign we_o    = wr_gnt_o;
  assign index_o = wr_gnt_o ? wr_index_i : rd_index_i;
  assign wdata_o = wr_data_i;
  assign strb_o  = wr_gnt_o ? wr_strb_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_wr_q <= 1'b0;
    end else if (wr_gnt_o) begin
      last_wr_q <= 1'b1;
    end else if (rd_gnt_o) begin
      last_wr_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sram_bank.sv
`timescale 1ns/1ns
`default_nettype none

module sram_bank #(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256,
  localparam int INDEX_BITS = $clog2(MEM_WORDS)
) (
  input  logic                    clk_i,
  input  logic                    cs_i,
  input  logic                    we_i,
  input  logic [INDEX_BITS-1:0]   index_i,
  input  logic [DATA_WIDTH-1:0]   wdata_i,
  input  logic [DATA_WIDTH/8-1:0] strb_i,
  output logic [DATA_WIDTH-1:0]   rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];
  logic [DATA_WIDTH-1:0] rdata_q;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cs_i && we_i) begin
      for (int b = 0; b < DATA_WIDTH / 8; b++) begin
        if (strb_i[b]) begin
          mem_q[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end else if (cs_i) begin
      rdata_q <= mem_q[index_i];  // holds until the next read access.
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: verilog/axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

  localparam int ID_BITS    = 4;
  localparam int LEN_BITS   = 8;  // a burst carries len + 1 beats.
  localparam int SIZE_BITS  = 3;
  localparam int BURST_BITS = 2;
  localparam int RESP_BITS  = 2;

  localparam logic [BURST_BITS-1:0] BURST_FIXED = 2'd0;  // every beat hits the same word.
  localparam logic [BURST_BITS-1:0] BURST_INCR  = 2'd1;
  localparam logic [BURST_BITS-1:0] BURST_WRAP  = 2'd2;  // always answered with SLVERR.

  localparam logic [RESP_BITS-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_BITS-1:0] RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire
